//--- Bender.yml
package:
  name: camera_metering

sources:
  - files:
      - hw/camera_metering_pkg.sv
      - hw/pixel_gain.sv
      - hw/metering.sv
      - hw/exposure_regulator.sv
      - hw/camera_metering.sv
  - target: simulation
    files:
      - sim/tb_clock_gen.sv
      - sim/camera_metering_tb.sv

//--- camera_metering.f
hw/camera_metering_pkg.sv
hw/pixel_gain.sv
hw/metering.sv
hw/exposure_regulator.sv
hw/camera_metering.sv
sim/tb_clock_gen.sv
sim/camera_metering_tb.sv

//--- hw/camera_metering.sv
// ##########################################################################
// Top level of the auto-exposure path: white-balance gain, centre-window
// metering and the exposure regulator in series. Meters update two cycles
// and exposure three cycles after frame_valid falls at the input.
// ##########################################################################

`timescale 1ns/1ps
`default_nettype none

module camera_metering #(
    parameter int FRAME_WIDTH    = 720,
    parameter int FRAME_HEIGHT   = 720,
    parameter int WINDOW_SIZE    = 512,
    parameter int EXPOSURE_RESET = 1000,
    parameter int EXPOSURE_MIN   = 16,
    parameter int EXPOSURE_MAX   = 20000,
    parameter int STEP_SHIFT     = 2,
    parameter int MAX_STEP       = 64
) (
    input  logic                                         clock_in,
    input  logic                                         rst,
    input  logic [camera_metering_pkg::PIXEL_BITS-1:0]    red_data,
    input  logic [camera_metering_pkg::PIXEL_BITS-1:0]    green_data,
    input  logic [camera_metering_pkg::PIXEL_BITS-1:0]    blue_data,
    input  logic                                         line_valid,
    input  logic                                         frame_valid,
    input  logic [camera_metering_pkg::GAIN_BITS-1:0]     red_gain,
    input  logic [camera_metering_pkg::GAIN_BITS-1:0]     green_gain,
    input  logic [camera_metering_pkg::GAIN_BITS-1:0]     blue_gain,
    input  logic [camera_metering_pkg::METER_BITS-1:0]    target_brightness,
    output logic [camera_metering_pkg::METER_BITS-1:0]    red_meter,
    output logic [camera_metering_pkg::METER_BITS-1:0]    green_meter,
    output logic [camera_metering_pkg::METER_BITS-1:0]    blue_meter,
    output logic                                         meter_done,
    output logic [camera_metering_pkg::EXPOSURE_BITS-1:0] exposure,
    output logic                                         exposure_valid
);

    import camera_metering_pkg::*;

    logic [PIXEL_BITS-1:0] gained_red;
    logic [PIXEL_BITS-1:0] gained_green;
    logic [PIXEL_BITS-1:0] gained_blue;
    logic                  gained_line_valid;
    logic                  gained_frame_valid;

    pixel_gain pixel_gain_inst (
        .clock_in        (clock_in),
        .rst             (rst),
        .red_data        (red_data),
        .green_data      (green_data),
        .blue_data       (blue_data),
        .line_valid      (line_valid),
        .frame_valid     (frame_valid),
        .red_gain        (red_gain),
        .green_gain      (green_gain),
        .blue_gain       (blue_gain),
        .red_out         (gained_red),
        .green_out       (gained_green),
        .blue_out        (gained_blue),
        .line_valid_out  (gained_line_valid),
        .frame_valid_out (gained_frame_valid)
    );

    metering #(
        .FRAME_WIDTH  (FRAME_WIDTH),
        .FRAME_HEIGHT (FRAME_HEIGHT),
        .WINDOW_SIZE  (WINDOW_SIZE)
    ) metering_inst (
        .clock_in    (clock_in),
        .rst         (rst),
        .red_data    (gained_red),
        .green_data  (gained_green),
        .blue_data   (gained_blue),
        .line_valid  (gained_line_valid),
        .frame_valid (gained_frame_valid),
        .red_meter   (red_meter),
        .green_meter (green_meter),
        .blue_meter  (blue_meter),
        .meter_done  (meter_done)
    );

    exposure_regulator #(
        .EXPOSURE_RESET (EXPOSURE_RESET),
        .EXPOSURE_MIN   (EXPOSURE_MIN),
        .EXPOSURE_MAX   (EXPOSURE_MAX),
        .STEP_SHIFT     (STEP_SHIFT),
        .MAX_STEP       (MAX_STEP)
    ) exposure_regulator_inst (
        .clock_in          (clock_in),
        .rst               (rst),
        .red_meter         (red_meter),
        .green_meter       (green_meter),
        .blue_meter        (blue_meter),
        .meter_done        (meter_done),
        .target_brightness (target_brightness),
        .exposure          (exposure),
        .exposure_valid    (exposure_valid)
    );

endmodule

`default_nettype wire

//--- hw/camera_metering_pkg.sv
// ##########################################################################
// Shared widths and constants for the camera auto-exposure metering path.
// Every RTL block and the testbench take their sample, meter, gain and
// exposure widths from here so the whole datapath stays consistent.
// ##########################################################################

`default_nettype none

package camera_metering_pkg;

    // Width of one colour channel sample from the sensor.
    parameter int PIXEL_BITS = 10;

    // Full-scale channel value, used as the saturation limit after gain.
    parameter logic [PIXEL_BITS-1:0] PIXEL_MAX = '1;

    // Width of each published channel average.
    parameter int METER_BITS = 8;

    // White-balance gains are unsigned fixed point.
    parameter int GAIN_BITS = 8;

    // A gain of 1 << GAIN_FRAC_BITS (64) passes the sample through unchanged.
    parameter int GAIN_FRAC_BITS = 6;

    // Width of the exposure value handed to the sensor control.
    parameter int EXPOSURE_BITS = 16;

    // Raster position counters, wide enough for frames up to 4095 pixels.
    parameter int COUNTER_BITS = 12;

endpackage

`default_nettype wire

//--- hw/exposure_regulator.sv
// ##########################################################################
// Exposure regulator. On each meter_done it forms a weighted brightness
// from the channel meters, compares it to the target and moves exposure by
// a proportional step, limited in size and kept inside the allowed range.
// The new exposure and exposure_valid appear one cycle after meter_done.
// ##########################################################################

`timescale 1ns/1ps
`default_nettype none

module exposure_regulator #(
    parameter int EXPOSURE_RESET = 1000,
    parameter int EXPOSURE_MIN   = 16,
    parameter int EXPOSURE_MAX   = 20000,
    parameter int STEP_SHIFT     = 2,
    parameter int MAX_STEP       = 64
) (
    input  logic                                         clock_in,
    input  logic                                         rst,
    input  logic [camera_metering_pkg::METER_BITS-1:0]    red_meter,
    input  logic [camera_metering_pkg::METER_BITS-1:0]    green_meter,
    input  logic [camera_metering_pkg::METER_BITS-1:0]    blue_meter,
    input  logic                                         meter_done,
    input  logic [camera_metering_pkg::METER_BITS-1:0]    target_brightness,
    output logic [camera_metering_pkg::EXPOSURE_BITS-1:0] exposure,
    output logic                                         exposure_valid
);

    import camera_metering_pkg::*;

    // Signed headroom for exposure plus or minus a step.
    localparam int CALC_BITS = EXPOSURE_BITS + 2;

    logic [METER_BITS+1:0]        luma_sum;
    logic [METER_BITS-1:0]        brightness;
    logic signed [METER_BITS:0]   error;
    logic signed [METER_BITS:0]   scaled_error;
    logic signed [CALC_BITS-1:0]  step;
    logic signed [CALC_BITS-1:0]  raw_exposure;
    logic [EXPOSURE_BITS-1:0]     next_exposure;

    // Green counts twice, as in a Bayer mosaic.
    assign luma_sum   = red_meter + (green_meter << 1) + blue_meter;
    assign brightness = luma_sum[METER_BITS+1:2];

    assign error        = signed'({1'b0, target_brightness}) - signed'({1'b0, brightness});
    assign scaled_error = error >>> STEP_SHIFT;

    always_comb begin
        if (scaled_error > MAX_STEP) begin
            step = CALC_BITS'(MAX_STEP);
        end else if (scaled_error < -MAX_STEP) begin
            step = -CALC_BITS'(MAX_STEP);
        end else begin
            step = CALC_BITS'(scaled_error); // Sign extended.
        end

        raw_exposure = signed'({2'b00, exposure}) + step;

        if (raw_exposure > EXPOSURE_MAX) begin
            next_exposure = EXPOSURE_BITS'(EXPOSURE_MAX);
        end else if (raw_exposure < EXPOSURE_MIN) begin
            next_exposure = EXPOSURE_BITS'(EXPOSURE_MIN);
        end else begin
            next_exposure = raw_exposure[EXPOSURE_BITS-1:0];
        end
    end

    always_ff @(posedge clock_in) begin
        if (rst) begin
            exposure       <= EXPOSURE_BITS'(EXPOSURE_RESET);
            exposure_valid <= 1'b0;
        end else begin
            exposure_valid <= meter_done;
            if (meter_done) begin
                exposure <= next_exposure;
            end
        end
    end

    exposure_in_range: assert property (
        @(posedge clock_in) disable iff (rst)
        (exposure >= EXPOSURE_MIN) && (exposure <= EXPOSURE_MAX)
    ) else $error("exposure outside its allowed range");

endmodule

`default_nettype wire

//--- hw/metering.sv
// ##########################################################################
// Centre-window metering. Tracks the raster position from the valid levels,
// sums every channel over a WINDOW_SIZE square centred in the frame and,
// when the frame ends, publishes each channel's 8-bit average together
// with a single-cycle meter_done strobe. Results hold until the next frame.
// ##########################################################################

`timescale 1ns/1ps
`default_nettype none

module metering #(
    parameter int FRAME_WIDTH  = 720,
    parameter int FRAME_HEIGHT = 720,
    parameter int WINDOW_SIZE  = 512 // Power of two, no larger than the frame.
) (
    input  logic                                      clock_in,
    input  logic                                      rst,
    input  logic [camera_metering_pkg::PIXEL_BITS-1:0] red_data,
    input  logic [camera_metering_pkg::PIXEL_BITS-1:0] green_data,
    input  logic [camera_metering_pkg::PIXEL_BITS-1:0] blue_data,
    input  logic                                      line_valid,
    input  logic                                      frame_valid,
    output logic [camera_metering_pkg::METER_BITS-1:0] red_meter,
    output logic [camera_metering_pkg::METER_BITS-1:0] green_meter,
    output logic [camera_metering_pkg::METER_BITS-1:0] blue_meter,
    output logic                                      meter_done
);

    import camera_metering_pkg::*;

    // Window bounds, half-open on the upper side.
    localparam int X_START = FRAME_WIDTH / 2 - WINDOW_SIZE / 2;
    localparam int X_END   = FRAME_WIDTH / 2 + WINDOW_SIZE / 2;
    localparam int Y_START = FRAME_HEIGHT / 2 - WINDOW_SIZE / 2;
    localparam int Y_END   = FRAME_HEIGHT / 2 + WINDOW_SIZE / 2;

    // Holds WINDOW_SIZE squared full-scale samples without overflow.
    localparam int SUM_BITS = $clog2(WINDOW_SIZE * WINDOW_SIZE) + PIXEL_BITS;

    logic [COUNTER_BITS-1:0] x_count;
    logic [COUNTER_BITS-1:0] y_count;
    logic                    prev_line_valid;
    logic                    prev_frame_valid;
    logic                    in_window;
    logic                    frame_end;
    logic [SUM_BITS-1:0]     red_sum;
    logic [SUM_BITS-1:0]     green_sum;
    logic [SUM_BITS-1:0]     blue_sum;

    assign in_window = line_valid
                    && (x_count >= X_START) && (x_count < X_END)
                    && (y_count >= Y_START) && (y_count < Y_END);

    assign frame_end = prev_frame_valid && !frame_valid; // First low cycle after a frame.

    // Raster position. A line ends on the falling edge of line_valid.
    always_ff @(posedge clock_in) begin
        if (rst || !frame_valid) begin
            x_count         <= '0;
            y_count         <= '0;
            prev_line_valid <= 1'b0;
        end else begin
            prev_line_valid <= line_valid;
            if (line_valid) begin
                x_count <= x_count + 1'b1;
            end else begin
                x_count <= '0;
                if (prev_line_valid) begin
                    y_count <= y_count + 1'b1;
                end
            end
        end
    end

    // Window sums, emptied between frames.
    always_ff @(posedge clock_in) begin
        if (rst || !frame_valid) begin
            red_sum   <= '0;
            green_sum <= '0;
            blue_sum  <= '0;
        end else if (in_window) begin
            red_sum   <= red_sum + red_data;
            green_sum <= green_sum + green_data;
            blue_sum  <= blue_sum + blue_data;
        end
    end

    // The top byte of each sum is the window average reduced to 8 bits.
    always_ff @(posedge clock_in) begin
        if (rst) begin
            prev_frame_valid <= 1'b0;
            meter_done       <= 1'b0;
            red_meter        <= '0;
            green_meter      <= '0;
            blue_meter       <= '0;
        end else begin
            prev_frame_valid <= frame_valid;
            meter_done       <= frame_end;
            if (frame_end) begin
                red_meter   <= red_sum[SUM_BITS-1 -: METER_BITS];
                green_meter <= green_sum[SUM_BITS-1 -: METER_BITS];
                blue_meter  <= blue_sum[SUM_BITS-1 -: METER_BITS];
            end
        end
    end

    done_single_pulse: assert property (
        @(posedge clock_in) disable iff (rst)
        meter_done |=> !meter_done
    ) else $error("meter_done held for more than one cycle");

    // Lines longer than the configured width would corrupt the window.
    line_within_width: assert property (
        @(posedge clock_in) disable iff (rst)
        line_valid |-> (x_count < FRAME_WIDTH)
    ) else $error("line longer than FRAME_WIDTH");

endmodule

`default_nettype wire

//--- hw/pixel_gain.sv
// ##########################################################################
// White-balance gain stage. Each channel is multiplied by its own fixed
// point gain, scaled back down and clipped to full scale. Pixels and the
// line and frame valid levels leave exactly one cycle after they arrive.
// ##########################################################################

`timescale 1ns/1ps
`default_nettype none

module pixel_gain (
    input  logic                                      clock_in,
    input  logic                                      rst,
    input  logic [camera_metering_pkg::PIXEL_BITS-1:0] red_data,
    input  logic [camera_metering_pkg::PIXEL_BITS-1:0] green_data,
    input  logic [camera_metering_pkg::PIXEL_BITS-1:0] blue_data,
    input  logic                                      line_valid,
    input  logic                                      frame_valid,
    input  logic [camera_metering_pkg::GAIN_BITS-1:0]  red_gain,
    input  logic [camera_metering_pkg::GAIN_BITS-1:0]  green_gain,
    input  logic [camera_metering_pkg::GAIN_BITS-1:0]  blue_gain,
    output logic [camera_metering_pkg::PIXEL_BITS-1:0] red_out,
    output logic [camera_metering_pkg::PIXEL_BITS-1:0] green_out,
    output logic [camera_metering_pkg::PIXEL_BITS-1:0] blue_out,
    output logic                                      line_valid_out,
    output logic                                      frame_valid_out
);

    import camera_metering_pkg::*;

    // Multiply, drop the fractional bits and clip at full scale.
    function automatic logic [PIXEL_BITS-1:0] apply_gain(
        input logic [PIXEL_BITS-1:0] sample,
        input logic [GAIN_BITS-1:0]  gain
    );
        logic [PIXEL_BITS+GAIN_BITS-1:0]                product;
        logic [PIXEL_BITS+GAIN_BITS-GAIN_FRAC_BITS-1:0] scaled;
        product = sample * gain;
        scaled  = product[PIXEL_BITS+GAIN_BITS-1:GAIN_FRAC_BITS]; // Integer part only.
        if (scaled > PIXEL_MAX) begin
            return PIXEL_MAX;
        end
        return scaled[PIXEL_BITS-1:0];
    endfunction

    // Gained pixel registers, one per channel.
    always_ff @(posedge clock_in) begin
        red_out   <= apply_gain(red_data, red_gain);
        green_out <= apply_gain(green_data, green_gain);
        blue_out  <= apply_gain(blue_data, blue_gain);
    end

    // Valid levels follow the same one cycle latency as the pixels.
    always_ff @(posedge clock_in) begin
        if (rst) begin
            line_valid_out  <= 1'b0;
            frame_valid_out <= 1'b0;
        end else begin
            line_valid_out  <= line_valid;
            frame_valid_out <= frame_valid;
        end
    end

    // The sensor only drives lines inside a frame.
    line_inside_frame: assert property (
        @(posedge clock_in) disable iff (rst)
        line_valid |-> frame_valid
    ) else $error("line_valid high while frame_valid is low");

endmodule

`default_nettype wire

//--- sim/camera_metering_tb.sv
// ##########################################################################
// Testbench for the camera metering top level. Each line of the data file
// describes one frame. The frame is driven as a raster, then the meters,
// the strobes and the exposure are checked in the gap after frame_valid.
// Run from the project root so the data file path resolves.
// ##########################################################################

`timescale 1ns/1ps
`default_nettype none

module camera_metering_tb;

    import camera_metering_pkg::*;

    localparam int FRAME_WIDTH      = 16;
    localparam int FRAME_HEIGHT     = 12;
    localparam int WINDOW_SIZE      = 8;
    localparam int EXPOSURE_RESET   = 1000;
    localparam int NUM_FRAMES       = 16;
    localparam int FIELDS           = 12; // Values per line of the data file.
    localparam int LINE_GAP         = 3;
    localparam int FRAME_GAP        = 6;
    localparam int CYCLES_PER_FRAME = 1 + FRAME_HEIGHT * (FRAME_WIDTH + LINE_GAP) + FRAME_GAP;
    localparam int CYCLE_LIMIT      = NUM_FRAMES * CYCLES_PER_FRAME + 100;
    localparam logic [15:0] RANDOM_MARK = 16'hffff; // Outside pixels come from $random.

    logic                     clock_in;
    logic                     rst;
    logic [PIXEL_BITS-1:0]    red_data;
    logic [PIXEL_BITS-1:0]    green_data;
    logic [PIXEL_BITS-1:0]    blue_data;
    logic                     line_valid;
    logic                     frame_valid;
    logic [GAIN_BITS-1:0]     red_gain;
    logic [GAIN_BITS-1:0]     green_gain;
    logic [GAIN_BITS-1:0]     blue_gain;
    logic [METER_BITS-1:0]    target_brightness;
    logic [METER_BITS-1:0]    red_meter;
    logic [METER_BITS-1:0]    green_meter;
    logic [METER_BITS-1:0]    blue_meter;
    logic                     meter_done;
    logic [EXPOSURE_BITS-1:0] exposure;
    logic                     exposure_valid;

    logic [15:0]              vectors [0:NUM_FRAMES*FIELDS-1];
    integer                   seed;
    int                       cycle_count  = 0;
    int                       error_count  = 0;
    int                       test_count   = 0;
    int                       failed_tests = 0;
    int                       done_pulses  = 0;
    int                       valid_pulses = 0;
    logic [METER_BITS-1:0]    held_red;
    logic [METER_BITS-1:0]    held_green;
    logic [METER_BITS-1:0]    held_blue;
    logic [EXPOSURE_BITS-1:0] held_exposure;

    tb_clock_gen #(
        .PERIOD_NS    (4.0),
        .RESET_CYCLES (4)
    ) tb_clock_gen_inst (
        .clock_in (clock_in),
        .rst      (rst)
    );

    camera_metering #(
        .FRAME_WIDTH    (FRAME_WIDTH),
        .FRAME_HEIGHT   (FRAME_HEIGHT),
        .WINDOW_SIZE    (WINDOW_SIZE),
        .EXPOSURE_RESET (EXPOSURE_RESET),
        .EXPOSURE_MIN   (990),
        .EXPOSURE_MAX   (1040),
        .STEP_SHIFT     (2),
        .MAX_STEP       (8)
    ) camera_metering_inst (
        .clock_in          (clock_in),
        .rst               (rst),
        .red_data          (red_data),
        .green_data        (green_data),
        .blue_data         (blue_data),
        .line_valid        (line_valid),
        .frame_valid       (frame_valid),
        .red_gain          (red_gain),
        .green_gain        (green_gain),
        .blue_gain         (blue_gain),
        .target_brightness (target_brightness),
        .red_meter         (red_meter),
        .green_meter       (green_meter),
        .blue_meter        (blue_meter),
        .meter_done        (meter_done),
        .exposure          (exposure),
        .exposure_valid    (exposure_valid)
    );

    // Strobe counters, so a missing or extra pulse anywhere shows up per frame.
    always @(posedge clock_in) begin
        if (!rst) begin
            done_pulses  <= done_pulses + meter_done;
            valid_pulses <= valid_pulses + exposure_valid;
        end
    end

    always @(posedge clock_in) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Result: FAILED");
            $finish;
        end
    end

    task automatic compare_value(input string name, input logic [31:0] actual,
                                 input logic [31:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED: %s is 0x%0h, expected 0x%0h", name, actual, expected);
            error_count++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        test_count++;
        if (error_count == errors_before) begin
            $display("%s: passed", name);
        end else begin
            failed_tests++;
            $display("%s: failed with %0d mismatches", name, error_count - errors_before);
        end
    endtask

    // Half-open centre window in both directions.
    function automatic logic inside_window(input int x, input int y);
        return (x >= FRAME_WIDTH / 2 - WINDOW_SIZE / 2) && (x < FRAME_WIDTH / 2 + WINDOW_SIZE / 2)
            && (y >= FRAME_HEIGHT / 2 - WINDOW_SIZE / 2) && (y < FRAME_HEIGHT / 2 + WINDOW_SIZE / 2);
    endfunction

    task automatic drive_pixel(input int base, input logic window);
        logic [31:0] rand_word;
        if (window) begin
            red_data   <= vectors[base+3][PIXEL_BITS-1:0];
            green_data <= vectors[base+4][PIXEL_BITS-1:0];
            blue_data  <= vectors[base+5][PIXEL_BITS-1:0];
        end else if (vectors[base+6] == RANDOM_MARK) begin
            rand_word = $random(seed);
            red_data   <= rand_word[9:0];
            green_data <= rand_word[19:10];
            blue_data  <= rand_word[29:20];
        end else begin
            red_data   <= vectors[base+6][PIXEL_BITS-1:0];
            green_data <= vectors[base+6][PIXEL_BITS-1:0];
            blue_data  <= vectors[base+6][PIXEL_BITS-1:0];
        end
    endtask

    task automatic run_frame(input int index);
        int base;
        int errors_before;
        int done_before;
        int valid_before;
        base          = index * FIELDS;
        errors_before = error_count;
        done_before   = done_pulses;
        valid_before  = valid_pulses;
        @(posedge clock_in);
        red_gain          <= vectors[base][GAIN_BITS-1:0];
        green_gain        <= vectors[base+1][GAIN_BITS-1:0];
        blue_gain         <= vectors[base+2][GAIN_BITS-1:0];
        target_brightness <= vectors[base+7][METER_BITS-1:0];
        frame_valid       <= 1'b1;
        for (int y = 0; y < FRAME_HEIGHT; y++) begin
            for (int x = 0; x < FRAME_WIDTH; x++) begin
                @(posedge clock_in);
                line_valid <= 1'b1;
                drive_pixel(base, inside_window(x, y));
            end
            if (y < FRAME_HEIGHT - 1) begin
                repeat (LINE_GAP) begin
                    @(posedge clock_in);
                    line_valid <= 1'b0;
                end
            end
        end
        // Meters land two cycles after frame_valid falls, exposure one later.
        for (int g = 0; g < FRAME_GAP; g++) begin
            @(posedge clock_in);
            frame_valid <= 1'b0;
            line_valid  <= 1'b0;
            @(negedge clock_in);
            if (g == 2) begin
                compare_value("meter_done", meter_done, 1'b1);
                held_red   = vectors[base+8][METER_BITS-1:0];
                held_green = vectors[base+9][METER_BITS-1:0];
                held_blue  = vectors[base+10][METER_BITS-1:0];
            end
            if (g == 3) begin
                compare_value("exposure_valid", exposure_valid, 1'b1);
                held_exposure = vectors[base+11][EXPOSURE_BITS-1:0];
            end
            compare_value("red_meter", red_meter, held_red);
            compare_value("green_meter", green_meter, held_green);
            compare_value("blue_meter", blue_meter, held_blue);
            compare_value("exposure", exposure, held_exposure);
        end
        compare_value("meter_done pulses", done_pulses - done_before, 1);
        compare_value("exposure_valid pulses", valid_pulses - valid_before, 1);
        report_test($sformatf("Frame %0d", index), errors_before);
    endtask

    initial begin
        bit data_ok;
        int errors_before;
        red_data          = '0;
        green_data        = '0;
        blue_data         = '0;
        line_valid        = 1'b0;
        frame_valid       = 1'b0;
        red_gain          = '0;
        green_gain        = '0;
        blue_gain         = '0;
        target_brightness = '0;
        seed              = 32'hca15;
        held_red          = '0;
        held_green        = '0;
        held_blue         = '0;
        held_exposure     = EXPOSURE_BITS'(EXPOSURE_RESET);
        data_ok           = 1'b1;

        $readmemh("sim/metering_input.txt", vectors);
        for (int i = 0; i < NUM_FRAMES * FIELDS; i++) begin
            if ($isunknown(vectors[i])) begin
                data_ok = 1'b0;
            end
        end
        if (!data_ok) begin
            $display("The data file sim/metering_input.txt is missing or has too few values");
            error_count++;
        end

        wait (rst === 1'b0);
        @(negedge clock_in);
        errors_before = error_count;
        compare_value("red_meter", red_meter, 0);
        compare_value("green_meter", green_meter, 0);
        compare_value("blue_meter", blue_meter, 0);
        compare_value("exposure", exposure, EXPOSURE_RESET);
        compare_value("meter_done", meter_done, 0);
        compare_value("exposure_valid", exposure_valid, 0);
        report_test("Reset state", errors_before);

        if (data_ok) begin
            for (int i = 0; i < NUM_FRAMES; i++) begin
                run_frame(i);
            end
        end

        $display("Summary: %0d tests run, %0d failed, %0d mismatches",
                 test_count, failed_tests, error_count);
        if (error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/metering_input.txt
// rgain ggain bgain | window r g b | outside (FFFF = random) | target
// | expected red green blue meter | expected exposure, all hex
40 40 40 190 0C8 064 0000 3C 64 32 19 3E9
40 40 40 3FF 200 003 FFFF 7F FF 80 00 3E9
40 40 40 000 000 000 03FF C8 00 00 00 3F1
80 80 80 064 0C8 12C 0000 FF 32 64 96 3F9
80 40 80 2BC 2BC 1FF 0000 FF FF AF FF 401
FF 20 60 12C 3E8 032 0155 B4 FF 7D 12 409
40 40 40 028 028 028 FFFF FA 0A 0A 0A 410
40 40 40 320 320 320 0000 00 C8 C8 C8 408
40 40 40 3FF 3FF 3FF FFFF 0A FF FF FF 400
40 40 40 200 100 080 03FF 45 80 40 20 3FF
40 40 40 258 258 258 0000 64 96 96 96 3F7
20 20 20 3E8 320 258 0000 46 7D 64 4B 3EF
40 40 40 3FC 3FC 3FC FFFF 00 FF FF FF 3E7
40 40 40 3FC 3FC 3FC FFFF 00 FF FF FF 3DF
40 40 40 3FC 3FC 3FC 03FF 00 FF FF FF 3DE
40 40 40 004 008 00C 0000 01 01 02 03 3DE

//--- sim/tb_clock_gen.sv
// ##########################################################################
// Testbench clock and reset source. Runs a free clock of PERIOD_NS and holds
// the synchronous reset high for RESET_CYCLES rising edges after time zero.
// ##########################################################################

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter real PERIOD_NS    = 4.0,
    parameter int  RESET_CYCLES = 4
) (
    output logic clock_in,
    output logic rst
);

    initial begin
        clock_in = 1'b0;
        forever #(PERIOD_NS / 2.0) clock_in = ~clock_in;
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock_in);
        rst <= 1'b0; // Released on a rising edge like any other input.
    end

endmodule

`default_nettype wire
